/* src/intPkg.sv */
`default_nettype none

package intPkg;

    localparam int tagWidth = 7;
    localparam int sqnWidth = 7;

    // top bit set means no register destination.
    typedef logic [tagWidth-1:0] Tag;

    // compared by wrap-around difference.
    typedef logic [sqnWidth-1:0] SqN;

    typedef enum logic [5:0] {
        INT_AUIPC,
        INT_ADD,
        INT_SUB,
        INT_XOR,
        INT_OR,
        INT_AND,
        INT_SLL,
        INT_SRL,
        INT_SRA,
        INT_SLT,
        INT_SLTU,
        INT_LUI,
        INT_JAL,
        INT_V_JR,
        INT_V_RET,
        INT_V_JALR,
        INT_SYS,
        INT_SH1ADD,
        INT_SH2ADD,
        INT_SH3ADD,
        INT_ANDN,
        INT_ORN,
        INT_XNOR,
        INT_SE_B,
        INT_SE_H,
        INT_ZE_H,
        INT_CLZ,
        INT_CTZ,
        INT_CPOP,
        INT_ORC_B,
        INT_MAX,
        INT_MAXU,
        INT_MIN,
        INT_MINU,
        INT_REV8,
        INT_FSGNJ_S,
        INT_FSGNJN_S,
        INT_FSGNJX_S,
        INT_BEQ, INT_BNE,
        INT_BLT, INT_BGE,
        INT_BLTU, INT_BGEU
    } IntOp;

    // values above PRED_NTAKEN arrive through the immediate of system ops.
    typedef enum logic [3:0] {
        FLAGS_NONE         = 4'd0,
        FLAGS_BRANCH       = 4'd1,
        FLAGS_PRED_TAKEN   = 4'd2,
        FLAGS_PRED_NTAKEN  = 4'd3,
        FLAGS_FENCE        = 4'd4,
        FLAGS_ORDERING     = 4'd5,
        FLAGS_ILLEGAL      = 4'd6,
        FLAGS_TRAP         = 4'd7,
        FLAGS_XRET         = 4'd8,
        FLAGS_BRK          = 4'd9
    } ResFlags;

endpackage

`default_nettype wire

/* src/bitCounter.sv */
`default_nettype none

module bitCounter (
    input wire [31:0] operand,
    input wire countTrailing,
    output logic [5:0] zeroCount,
    output logic [5:0] popCount
);

    logic [31:0] scan;
    logic [15:0] scan16;
    logic [7:0] scan8;
    logic [3:0] scan4;
    logic [1:0] scan2;
    logic [4:0] lz;
    logic [2:0] nibCnt [8];
    logic [3:0] byteCnt [4];
    logic [4:0] halfCnt [2];

    // trailing zeros become leading zeros of the mirrored word.
    always_comb begin
        for (int i = 0; i < 32; i++) begin
            scan[i] = countTrailing ? operand[31-i] : operand[i];
        end
    end

    // halve the window at each level.
    always_comb begin
        lz[4] = ~|scan[31:16];
        scan16 = lz[4] ? scan[15:0] : scan[31:16];
        lz[3] = ~|scan16[15:8];
        scan8 = lz[3] ? scan16[7:0] : scan16[15:8];
        lz[2] = ~|scan8[7:4];
        scan4 = lz[2] ? scan8[3:0] : scan8[7:4];
        lz[1] = ~|scan4[3:2];
        scan2 = lz[1] ? scan4[1:0] : scan4[3:2];
        lz[0] = ~scan2[1];
    end

    assign zeroCount = (scan == 32'b0) ? 6'd32 : {1'b0, lz};

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            nibCnt[i] = {2'b0, operand[4*i]} + {2'b0, operand[4*i+1]}
                + {2'b0, operand[4*i+2]} + {2'b0, operand[4*i+3]};
        end
        for (int i = 0; i < 4; i++) begin
            byteCnt[i] = {1'b0, nibCnt[2*i]} + {1'b0, nibCnt[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            halfCnt[i] = {1'b0, byteCnt[2*i]} + {1'b0, byteCnt[2*i+1]};
        end
        popCount = {1'b0, halfCnt[0]} + {1'b0, halfCnt[1]};
    end

endmodule

`default_nettype wire

/* src/intAlu.sv */
`default_nettype none

module intAlu #(
    parameter int histLen = 8
) (
    input wire clk,
    input wire rst,
    input wire en,
    input wire uopValid,
    input wire intPkg::IntOp opcode,
    input wire [31:0] srcA,
    input wire [31:0] srcB,
    input wire [31:0] imm,
    input wire [31:0] pc,
    input wire compressed,
    input wire intPkg::Tag tagDst,
    input wire intPkg::SqN sqN,
    input wire predicted,
    input wire predTaken,
    input wire [histLen-1:0] history,
    input wire wbStall,
    input wire invalidate,
    input wire intPkg::SqN invalidateSqN,
    output logic wbReq,
    output logic zcValid,
    output intPkg::Tag zcTag,
    output logic [31:0] zcResult,
    output logic resValid,
    output intPkg::Tag resTag,
    output intPkg::SqN resSqN,
    output logic [31:0] resResult,
    output intPkg::ResFlags resFlags,
    output logic brTaken,
    output logic [31:0] brDstPC,
    output intPkg::SqN brSqN,
    output logic [histLen-1:0] brHistory,
    output logic btValid,
    output logic [31:0] btSrc,
    output logic [31:0] btDst,
    output logic btIsJump,
    output logic btIsCall,
    output logic btCompressed
);

    import intPkg::*;

    logic [31:0] result;
    ResFlags flags;
    logic [5:0] zeroCount;
    logic [5:0] popCount;
    logic lessThan;
    logic lessThanU;
    logic [31:0] pcPlus2;
    logic [31:0] pcPlus4;
    logic [31:0] branchDst;
    logic [31:0] indDst;
    logic isBranch;
    logic isIndirect;
    logic branchTaken;
    logic redirect;
    logic btbUpdate;
    logic [31:0] redirectPC;
    logic [histLen-1:0] nextHistory;
    logic accept;

    bitCounter bitCount (
        .operand(srcA),
        .countTrailing(opcode == INT_CTZ),
        .zeroCount(zeroCount),
        .popCount(popCount)
    );

    assign lessThan = $signed(srcA) < $signed(srcB);
    assign lessThanU = srcA < srcB;
    assign pcPlus2 = pc + 32'd2;
    assign pcPlus4 = pc + 32'd4;
    assign branchDst = pc + {{19{imm[12]}}, imm[12:0]};

    assign wbReq = uopValid && en;
    assign zcValid = uopValid && en && !tagDst[tagWidth-1];
    assign zcTag = tagDst;
    assign zcResult = result;

    always_comb begin
        case (opcode)
            INT_AUIPC: result = pc + imm;
            INT_ADD: result = srcA + srcB;
            INT_SUB: result = srcA - srcB;
            INT_XOR: result = srcA ^ srcB;
            INT_OR: result = srcA | srcB;
            INT_AND: result = srcA & srcB;
            INT_SLL: result = srcA << srcB[4:0];
            INT_SRL: result = srcA >> srcB[4:0];
            INT_SRA: result = $signed(srcA) >>> srcB[4:0];
            INT_SLT: result = {31'b0, lessThan};
            INT_SLTU: result = {31'b0, lessThanU};
            INT_LUI: result = srcB;
            INT_JAL,
            INT_V_JR,
            INT_V_RET,
            INT_V_JALR: result = compressed ? pcPlus2 : pcPlus4;
            INT_SH1ADD: result = srcB + (srcA << 1);
            INT_SH2ADD: result = srcB + (srcA << 2);
            INT_SH3ADD: result = srcB + (srcA << 3);
            INT_ANDN: result = srcA & ~srcB;
            INT_ORN: result = srcA | ~srcB;
            INT_XNOR: result = srcA ^ ~srcB;
            INT_SE_B: result = {{24{srcA[7]}}, srcA[7:0]};
            INT_SE_H: result = {{16{srcA[15]}}, srcA[15:0]};
            INT_ZE_H: result = {16'b0, srcA[15:0]};
            INT_CLZ,
            INT_CTZ: result = {26'b0, zeroCount};
            INT_CPOP: result = {26'b0, popCount};
            INT_ORC_B: result = {{8{|srcA[31:24]}}, {8{|srcA[23:16]}},
                                 {8{|srcA[15:8]}}, {8{|srcA[7:0]}}};
            INT_MAX: result = lessThan ? srcB : srcA;
            INT_MAXU: result = lessThanU ? srcB : srcA;
            INT_MIN: result = lessThan ? srcA : srcB;
            INT_MINU: result = lessThanU ? srcA : srcB;
            INT_REV8: result = {srcA[7:0], srcA[15:8], srcA[23:16], srcA[31:24]};
            INT_FSGNJ_S: result = {srcB[31], srcA[30:0]};
            INT_FSGNJN_S: result = {~srcB[31], srcA[30:0]};
            INT_FSGNJX_S: result = {srcA[31] ^ srcB[31], srcA[30:0]};
            // sys and conditional branches write zero.
            default: result = 32'b0;
        endcase
    end

    always_comb begin
        isBranch = 1'b1;
        case (opcode)
            INT_BEQ: branchTaken = srcA == srcB;
            INT_BNE: branchTaken = srcA != srcB;
            INT_BLT: branchTaken = lessThan;
            INT_BGE: branchTaken = !lessThan;
            INT_BLTU: branchTaken = lessThanU;
            INT_BGEU: branchTaken = !lessThanU;
            default: begin
                isBranch = 1'b0;
                branchTaken = 1'b0;
            end
        endcase
        isIndirect = opcode inside {INT_V_RET, INT_V_JR, INT_V_JALR};

        // ret jumps to srcA as is, the others add the 12-bit offset.
        indDst = (opcode == INT_V_RET) ? srcA : srcA + {{20{imm[11]}}, imm[11:0]};
        indDst[0] = 1'b0;

        if (isBranch) begin
            redirect = branchTaken != predTaken;
            btbUpdate = branchTaken && !predicted;
            redirectPC = branchTaken ? branchDst : (compressed ? pcPlus2 : pcPlus4);
            nextHistory = {history[histLen-2:0], branchTaken};
            flags = !predicted ? FLAGS_BRANCH :
                    (branchTaken ? FLAGS_PRED_TAKEN : FLAGS_PRED_NTAKEN);
        end else begin
            redirect = isIndirect && (indDst[31:1] != srcB[31:1]);
            btbUpdate = redirect && (opcode != INT_V_RET);
            redirectPC = indDst;
            nextHistory = history;
            flags = (opcode == INT_SYS) ? ResFlags'(imm[3:0]) : FLAGS_NONE;
        end
    end

    assign accept = uopValid && en && !wbStall
        && (!invalidate || $signed(sqN - invalidateSqN) <= 0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            resValid <= 1'b0;
            brTaken <= 1'b0;
            btValid <= 1'b0;
        end else begin
            resValid <= accept;
            brTaken <= accept && redirect;
            btValid <= accept && btbUpdate;
        end
    end

    // payload only moves on acceptance.
    always_ff @(posedge clk) begin
        if (accept) begin
            resTag <= tagDst;
            resSqN <= sqN;
            resResult <= result;
            resFlags <= flags;
            brDstPC <= redirectPC;
            brSqN <= sqN;
            brHistory <= nextHistory;
            // uncompressed ops are predicted from their second halfword.
            btSrc <= compressed ? pc : pcPlus2;
            btDst <= isBranch ? branchDst : indDst;
            btIsJump <= !isBranch;
            btIsCall <= opcode == INT_V_JALR;
            btCompressed <= compressed;
        end
    end

    // both count trees see the same operand.
    countsEmpty: assert property (@(posedge clk) disable iff (!rst)
        (popCount == 6'd0) == (zeroCount == 6'd32));
    countsFit: assert property (@(posedge clk) disable iff (!rst)
        {1'b0, popCount} + {1'b0, zeroCount} <= 7'd32);
    // a jump update comes with the redirect to the same target.
    jumpUpdateRedirects: assert property (@(posedge clk) disable iff (!rst)
        btValid && btIsJump |-> brTaken && btDst == brDstPC);

endmodule

`default_nettype wire

/* src/intExecUnit.sv */
`default_nettype none

module intExecUnit #(
    parameter int histLen = 8
) (
    input wire clk,
    input wire rst,
    input wire en,
    input wire uopValid,
    input wire intPkg::IntOp opcode,
    input wire [31:0] srcA,
    input wire [31:0] srcB,
    input wire [31:0] imm,
    input wire [31:0] pc,
    input wire compressed,
    input wire intPkg::Tag tagDst,
    input wire intPkg::SqN sqN,
    input wire predicted,
    input wire predTaken,
    input wire [histLen-1:0] history,
    input wire wbStall,
    input wire invalidate,
    input wire intPkg::SqN invalidateSqN,
    output logic wbReq,
    output logic zcValid,
    output intPkg::Tag zcTag,
    output logic [31:0] zcResult,
    output logic resValid,
    output intPkg::Tag resTag,
    output intPkg::SqN resSqN,
    output logic [31:0] resResult,
    output intPkg::ResFlags resFlags,
    output logic brTaken,
    output logic [31:0] brDstPC,
    output intPkg::SqN brSqN,
    output logic [histLen-1:0] brHistory,
    output logic btValid,
    output logic [31:0] btSrc,
    output logic [31:0] btDst,
    output logic btIsJump,
    output logic btIsCall,
    output logic btCompressed
);

    // single execute lane.
    intAlu #(
        .histLen(histLen)
    ) alu (
        .clk, .rst, .en, .uopValid, .opcode, .srcA, .srcB, .imm, .pc,
        .compressed, .tagDst, .sqN, .predicted, .predTaken, .history,
        .wbStall, .invalidate, .invalidateSqN,
        .wbReq, .zcValid, .zcTag, .zcResult,
        .resValid, .resTag, .resSqN, .resResult, .resFlags,
        .brTaken, .brDstPC, .brSqN, .brHistory,
        .btValid, .btSrc, .btDst, .btIsJump, .btIsCall, .btCompressed
    );

endmodule

`default_nettype wire

/* verif/intAluModel.sv */
`default_nettype none

package intAluModel;

    import intPkg::*;

    typedef struct packed {
        logic valid;
        Tag tag;
        SqN sqN;
        logic [31:0] value;
        ResFlags flags;
        logic brTaken;
        logic [31:0] brDst;
        logic [31:0] hist;
        logic btValid;
        logic [31:0] btSrc;
        logic [31:0] btDst;
        logic btIsJump;
        logic btIsCall;
        logic btCompressed;
    } Expect;

    // older or equal to the flush point survives.
    function automatic logic notYounger(SqN s, SqN flushSqN);
        SqN diff;
        diff = s - flushSqN;
        return diff == '0 || diff[sqnWidth-1];
    endfunction

    function automatic logic [31:0] expectedValue(IntOp op, logic [31:0] a, logic [31:0] b,
            logic [31:0] imm, logic [31:0] pc, logic compressed);
        logic [31:0] v;
        v = '0;
        case (op)
            INT_AUIPC: v = pc + imm;
            INT_ADD: v = a + b;
            INT_SUB: v = a - b;
            INT_XOR: v = a ^ b;
            INT_OR: v = a | b;
            INT_AND: v = a & b;
            INT_SLL: v = a << b[4:0];
            INT_SRL: v = a >> b[4:0];
            INT_SRA: v = $signed(a) >>> b[4:0];
            INT_SLT: v = {31'b0, $signed(a) < $signed(b)};
            INT_SLTU: v = {31'b0, a < b};
            INT_LUI: v = b;
            INT_JAL, INT_V_JR, INT_V_RET, INT_V_JALR: v = pc + (compressed ? 32'd2 : 32'd4);
            INT_SH1ADD: v = (a << 1) + b;
            INT_SH2ADD: v = (a << 2) + b;
            INT_SH3ADD: v = (a << 3) + b;
            INT_ANDN: v = a & ~b;
            INT_ORN: v = a | ~b;
            INT_XNOR: v = ~(a ^ b);
            INT_SE_B: v = 32'($signed(a[7:0]));
            INT_SE_H: v = 32'($signed(a[15:0]));
            INT_ZE_H: v = {16'b0, a[15:0]};
            INT_CLZ: begin
                v = 32;
                for (int i = 0; i < 32; i++) begin
                    if (a[i]) v = 31 - i;
                end
            end
            INT_CTZ: begin
                v = 32;
                for (int i = 31; i >= 0; i--) begin
                    if (a[i]) v = i;
                end
            end
            INT_CPOP: v = 32'($countones(a));
            INT_ORC_B: begin
                for (int i = 0; i < 4; i++) begin
                    v[8*i+:8] = (a[8*i+:8] != 8'h00) ? 8'hff : 8'h00;
                end
            end
            INT_MAX: v = ($signed(a) > $signed(b)) ? a : b;
            INT_MAXU: v = (a > b) ? a : b;
            INT_MIN: v = ($signed(a) < $signed(b)) ? a : b;
            INT_MINU: v = (a < b) ? a : b;
            INT_REV8: v = {<<8{a}};
            INT_FSGNJ_S: v = {b[31], a[30:0]};
            INT_FSGNJN_S: v = {~b[31], a[30:0]};
            INT_FSGNJX_S: v = {a[31] ^ b[31], a[30:0]};
            default: v = '0;
        endcase
        return v;
    endfunction

    function automatic Expect predict(IntOp op, logic [31:0] a, logic [31:0] b,
            logic [31:0] imm, logic [31:0] pc, logic compressed, Tag tag, SqN sqN,
            logic predicted, logic predTaken, logic [31:0] history, int histLen);
        Expect e;
        logic taken;
        logic isBranch;
        logic [31:0] target;
        e = '0;
        e.valid = 1'b1;
        e.tag = tag;
        e.sqN = sqN;
        e.value = expectedValue(op, a, b, imm, pc, compressed);
        e.flags = (op == INT_SYS) ? ResFlags'(imm[3:0]) : FLAGS_NONE;
        e.hist = history;
        e.btSrc = compressed ? pc : pc + 32'd2;
        e.btCompressed = compressed;
        isBranch = 1'b1;
        case (op)
            INT_BEQ: taken = a == b;
            INT_BNE: taken = a != b;
            INT_BLT: taken = $signed(a) < $signed(b);
            INT_BGE: taken = $signed(a) >= $signed(b);
            INT_BLTU: taken = a < b;
            INT_BGEU: taken = a >= b;
            default: begin
                isBranch = 1'b0;
                taken = 1'b0;
            end
        endcase
        if (isBranch) begin
            target = pc + 32'($signed(imm[12:0]));
            e.brTaken = taken != predTaken;
            e.brDst = taken ? target : pc + (compressed ? 32'd2 : 32'd4);
            e.hist = ((history << 1) | 32'(taken)) & ((32'd1 << histLen) - 32'd1);
            e.flags = !predicted ? FLAGS_BRANCH : (taken ? FLAGS_PRED_TAKEN : FLAGS_PRED_NTAKEN);
            e.btValid = taken && !predicted;
            e.btDst = target;
        end else if (op inside {INT_V_RET, INT_V_JR, INT_V_JALR}) begin
            target = (op == INT_V_RET) ? a : a + 32'($signed(imm[11:0]));
            target[0] = 1'b0;
            // predicted target rides in srcB.
            e.brTaken = target[31:1] != b[31:1];
            e.brDst = target;
            e.btValid = e.brTaken && op != INT_V_RET;
            e.btDst = target;
            e.btIsJump = 1'b1;
            e.btIsCall = op == INT_V_JALR;
        end
        return e;
    endfunction

endpackage

`default_nettype wire

/* verif/intExecUnitTb.sv */
`default_nettype none

module intExecUnitTb;

    timeunit 1ns;
    timeprecision 100ps;

    import intPkg::*;
    import intAluModel::*;

    localparam int histLen = 8;
    localparam int numCycles = 4000;
    localparam int resetCycles = 16;
    localparam int cycleLimit = numCycles + resetCycles + 100;

    logic clk = 1'b0;
    logic rst;
    logic en;
    logic uopValid;
    IntOp opcode;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] imm;
    logic [31:0] pc;
    logic compressed;
    Tag tagDst;
    SqN sqN;
    logic predicted;
    logic predTaken;
    logic [histLen-1:0] history;
    logic wbStall;
    logic invalidate;
    SqN invalidateSqN;
    logic wbReq;
    logic zcValid;
    Tag zcTag;
    logic [31:0] zcResult;
    logic resValid;
    Tag resTag;
    SqN resSqN;
    logic [31:0] resResult;
    ResFlags resFlags;
    logic brTaken;
    logic [31:0] brDstPC;
    SqN brSqN;
    logic [histLen-1:0] brHistory;
    logic btValid;
    logic [31:0] btSrc;
    logic [31:0] btDst;
    logic btIsJump;
    logic btIsCall;
    logic btCompressed;
    Expect expQ[$];
    int cycleCount = 0;

    intExecUnit #(
        .histLen(histLen)
    ) i_intExecUnit (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            abortRun("Timeout: the run went past its cycle limit without finishing.");
        end
    end

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run aborted");
    endtask

    task automatic mismatch(string field, logic [31:0] got, logic [31:0] want);
        abortRun($sformatf("FAILED at %0d ns: %s is 0x%08h, expected 0x%08h",
            $time, field, got, want));
    endtask

    task automatic checkResult(Tag tag, SqN sqN, logic [31:0] value, ResFlags flags);
        if (resValid !== 1'b1) mismatch("resValid", 32'(resValid), 32'd1);
        if (resTag !== tag) mismatch("resTag", 32'(resTag), 32'(tag));
        if (resSqN !== sqN) mismatch("resSqN", 32'(resSqN), 32'(sqN));
        if (resResult !== value) mismatch("resResult", resResult, value);
        if (resFlags !== flags) mismatch("resFlags", 32'(resFlags), 32'(flags));
    endtask

    task automatic checkBranch(logic taken, SqN sqN, logic [31:0] dstPC,
            logic [histLen-1:0] hist);
        if (brTaken !== taken) mismatch("brTaken", 32'(brTaken), 32'(taken));
        if (taken) begin
            if (brSqN !== sqN) mismatch("brSqN", 32'(brSqN), 32'(sqN));
            if (brDstPC !== dstPC) mismatch("brDstPC", brDstPC, dstPC);
            if (brHistory !== hist) mismatch("brHistory", 32'(brHistory), 32'(hist));
        end
    endtask

    task automatic checkBtUpdate(logic valid, logic [31:0] src, logic [31:0] dst,
            logic isJump, logic isCall, logic isCompressed);
        if (btValid !== valid) mismatch("btValid", 32'(btValid), 32'(valid));
        if (valid) begin
            if (btSrc !== src) mismatch("btSrc", btSrc, src);
            if (btDst !== dst) mismatch("btDst", btDst, dst);
            if (btIsJump !== isJump) mismatch("btIsJump", 32'(btIsJump), 32'(isJump));
            if (btIsCall !== isCall) mismatch("btIsCall", 32'(btIsCall), 32'(isCall));
            if (btCompressed !== isCompressed) begin
                mismatch("btCompressed", 32'(btCompressed), 32'(isCompressed));
            end
        end
    endtask

    task automatic checkForward(logic req, logic valid, Tag tag, logic [31:0] value);
        if (wbReq !== req) mismatch("wbReq", 32'(wbReq), 32'(req));
        if (zcValid !== valid) mismatch("zcValid", 32'(zcValid), 32'(valid));
        if (valid) begin
            if (zcTag !== tag) mismatch("zcTag", 32'(zcTag), 32'(tag));
            if (zcResult !== value) mismatch("zcResult", zcResult, value);
        end
    endtask

    task automatic compareOutputs(Expect e);
        if (!e.valid) begin
            if (resValid !== 1'b0) mismatch("resValid", 32'(resValid), 32'd0);
            checkBranch(1'b0, '0, '0, '0);
            checkBtUpdate(1'b0, '0, '0, 1'b0, 1'b0, 1'b0);
        end else begin
            checkResult(e.tag, e.sqN, e.value, e.flags);
            checkBranch(e.brTaken, e.sqN, e.brDst, e.hist[histLen-1:0]);
            checkBtUpdate(e.btValid, e.btSrc, e.btDst, e.btIsJump, e.btIsCall,
                e.btCompressed);
        end
    endtask

    task automatic clearInputs();
        en = 1'b0;
        uopValid = 1'b0;
        opcode = INT_ADD;
        srcA = '0;
        srcB = '0;
        imm = '0;
        pc = '0;
        compressed = 1'b0;
        tagDst = '0;
        sqN = '0;
        predicted = 1'b0;
        predTaken = 1'b0;
        history = '0;
        wbStall = 1'b0;
        invalidate = 1'b0;
        invalidateSqN = '0;
    endtask

    task automatic drawUop();
        logic [31:0] rnd;
        rnd = $urandom;
        uopValid = $urandom_range(0, 3) != 0;
        en = $urandom_range(0, 7) != 0;
        wbStall = $urandom_range(0, 7) == 0;
        invalidate = $urandom_range(0, 3) == 0;
        invalidateSqN = SqN'($urandom);
        opcode = IntOp'(6'($urandom_range(0, 43)));
        srcA = ($urandom_range(0, 1) == 0) ? $urandom : $urandom >> $urandom_range(0, 31);
        imm = $urandom;
        // equal operands, short shifts and matching jump targets come up often.
        case ($urandom_range(0, 3))
            0: srcB = srcA;
            1: srcB = $urandom_range(0, 31);
            2: srcB = srcA + 32'($signed(imm[11:0]));
            default: srcB = $urandom;
        endcase
        pc = $urandom & ~32'd1;
        compressed = $urandom_range(0, 1) == 1;
        tagDst = Tag'($urandom);
        sqN = SqN'($urandom);
        predicted = $urandom_range(0, 1) == 1;
        predTaken = $urandom_range(0, 1) == 1;
        history = rnd[histLen-1:0];
    endtask

    initial begin
        Expect none;
        Expect next;
        none = '0;
        void'($urandom(32'h34eb_54e6));
        clearInputs();
        rst = 1'b0;
        repeat (resetCycles) begin
            @(negedge clk);
            compareOutputs(none);
        end
        rst = 1'b1;
        repeat (numCycles) begin
            drawUop();
            #5;
            next = predict(opcode, srcA, srcB, imm, pc, compressed, tagDst, sqN,
                predicted, predTaken, 32'(history), histLen);
            checkForward(uopValid && en, uopValid && en && !tagDst[tagWidth-1],
                tagDst, next.value);
            if (uopValid && en && !wbStall
                    && (!invalidate || notYounger(sqN, invalidateSqN))) begin
                expQ.push_back(next);
            end else begin
                expQ.push_back(none);
            end
            @(negedge clk);
            compareOutputs(expQ.pop_front());
        end
        clearInputs();
        @(negedge clk);
        compareOutputs(none);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
src/intPkg.sv
src/bitCounter.sv
src/intAlu.sv
src/intExecUnit.sv
verif/intAluModel.sv
verif/intExecUnitTb.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
        --top-module intExecUnitTb -o intExecUnitSim \
    && ./obj_dir/intExecUnitSim | tee /dev/stderr | grep -q "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
